// File: common/fetch_cfg.svh
// Widths and limits of the instruction fetch unit
// The bus width must be a whole multiple of the instruction width
// The fetch limit must be a power of two since it also sizes the FIFO
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// AXI-lite read bus
`define FETCH_AW 32
`define FETCH_BUS_DW 64

// CPU side
`define FETCH_INSN_W 32
`define FETCH_INSNS_PER_WORD (`FETCH_BUS_DW / `FETCH_INSN_W)

// Reads in flight plus words buffered, never more than this
`define FETCH_LIMIT 16

// Outstanding and discard counters, with plenty of headroom
`define FETCH_CNT_W ($clog2(`FETCH_LIMIT) + 4)

`endif

// File: common/fetch_pkg.sv
// Types shared by the fetch unit blocks
// Byte lanes are little-endian on the bus, instructions are big-endian

`include "fetch_cfg.svh"

package fetch_pkg;

	////////////////////////////////////////////////////////////
	// One bus word, seen as bytes or as instructions
	////////////////////////////////////////////////////////////

	// Byte view is used by the byte swap, insn view by the splitter
	typedef union packed {
		logic [`FETCH_BUS_DW/8-1:0][7:0] bytes;
		logic [`FETCH_INSNS_PER_WORD-1:0][`FETCH_INSN_W-1:0] insns;
	} bus_beat_u;

	// FIFO payload, word as it came off the bus plus RRESP[1]
	typedef struct packed {
		logic err;
		bus_beat_u word;
	} fifo_entry_t;

	////////////////////////////////////////////////////////////
	// Flush command built from the CPU strobes
	////////////////////////////////////////////////////////////

	typedef struct packed {
		// Any of CPU reset, cache clear or new PC
		logic flush;
		// A new PC comes with this flush
		logic new_pc;
		// CPU reset or cache clear, requests stop until a new PC
		logic halt;
	} flush_cmd_t;

endpackage

// File: verilog/fetch_request.sv
// Responses must return in issue order, RREADY is taken as always high
// The first request after reset goes out before any PC has been given

`timescale 1ns/1ns
`include "fetch_cfg.svh"

module fetch_request (
	input  logic                  S_AXI_ACLK,
	input  logic                  fifo_reset,
	input  fetch_pkg::flush_cmd_t i_flush,
	input  logic [`FETCH_AW-1:0]  i_pc,
	input  logic                  i_arready,
	input  logic                  i_rvalid,
	input  logic                  i_consumed,
	output logic                  o_arvalid,
	output logic [`FETCH_AW-1:0]  o_araddr,
	output logic                  o_keep
);

	localparam int LSB = $clog2(`FETCH_BUS_DW / 8);
	localparam int CW = `FETCH_CNT_W;

	logic ar_hs;
	logic ar_free;
	logic [CW-1:0] outstanding;
	logic [CW-1:0] next_outstanding;
	logic [CW-1:0] buffered;
	logic [CW-1:0] next_buffered;
	logic [CW-1:0] flushcount;
	logic [CW-1:0] new_flushcount;
	logic [CW:0] next_total;
	logic halted;
	logic next_halted;
	logic pending_new_pc;
	logic [`FETCH_AW-1:0] pending_pc;

	assign ar_hs = o_arvalid && i_arready;
	// Address may change only when no request is waiting
	assign ar_free = !o_arvalid || i_arready;

	////////////////////////////////////////////////////////////
	// Read accounting
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case ({ar_hs, i_rvalid})
		2'b10: next_outstanding = outstanding + 1'b1;
		2'b01: next_outstanding = outstanding - 1'b1;
		default: next_outstanding = outstanding;
		endcase
	end

	// Words kept but not yet fully handed to the CPU
	always_comb
	begin
		if (i_flush.flush)
			next_buffered = '0;
		else
		begin
			case ({o_keep, i_consumed})
			2'b10: next_buffered = buffered + 1'b1;
			2'b01: next_buffered = buffered - 1'b1;
			default: next_buffered = buffered;
			endcase
		end
	end

	assign next_total = {1'b0, next_outstanding} + {1'b0, next_buffered};

	// Everything in flight now, plus a request still on the channel
	assign new_flushcount = outstanding + CW'(o_arvalid) - CW'(i_rvalid);

	// Halt sticks until a new PC arrives
	always_comb
	begin
		next_halted = halted;
		if (i_flush.new_pc)
			next_halted = 1'b0;
		else if (i_flush.halt)
			next_halted = 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			outstanding <= '0;
			buffered <= '0;
			halted <= 1'b0;
		end
		else
		begin
			outstanding <= next_outstanding;
			buffered <= next_buffered;
			halted <= next_halted;
		end
	end

	////////////////////////////////////////////////////////////
	// Discard of responses to reads issued before a flush
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			flushcount <= '0;
		else if (i_flush.flush)
			flushcount <= new_flushcount;
		else if (i_rvalid && flushcount != '0)
			flushcount <= flushcount - 1'b1;
	end

	assign o_keep = i_rvalid && (flushcount == '0);

	////////////////////////////////////////////////////////////
	// AR channel
	////////////////////////////////////////////////////////////

	// Throttle on reads in flight plus words still buffered
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			o_arvalid <= 1'b0;
		else if (ar_free)
			o_arvalid <= !next_halted && (next_total < (CW+1)'(`FETCH_LIMIT));
	end

	// New PC seen while a request is stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			pending_new_pc <= 1'b0;
		else if (ar_free || (i_flush.halt && !i_flush.new_pc))
			pending_new_pc <= 1'b0;
		else if (i_flush.new_pc)
			pending_new_pc <= 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_flush.new_pc)
			pending_pc <= i_pc;
	end

	// Step by one bus word, aligned, after each issued request
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_free)
		begin
			if (i_flush.new_pc)
				o_araddr <= i_pc;
			else if (pending_new_pc)
				o_araddr <= pending_pc;
			else if (o_arvalid)
			begin
				o_araddr[`FETCH_AW-1:LSB] <= o_araddr[`FETCH_AW-1:LSB] + 1'b1;
				o_araddr[LSB-1:0] <= '0;
			end
		end
	end

endmodule

// File: verilog/sync_fifo.sv
// First-word fall-through FIFO, o_data is valid whenever o_empty is low
// DEPTH must be a power of two, writes to a full FIFO are dropped

`timescale 1ns/1ns
`include "fetch_cfg.svh"

module sync_fifo #(
	parameter int DEPTH = `FETCH_LIMIT
) (
	input  logic                   S_AXI_ACLK,
	input  logic                   fifo_reset,
	input  logic                   i_clear,
	input  logic                   i_wr,
	input  fetch_pkg::fifo_entry_t i_data,
	input  logic                   i_rd,
	output fetch_pkg::fifo_entry_t o_data,
	output logic                   o_empty
);

	localparam int PW = $clog2(DEPTH);

	fetch_pkg::fifo_entry_t mem [DEPTH];
	// Pointers carry one extra bit to tell full from empty
	logic [PW:0] wr_ptr;
	logic [PW:0] rd_ptr;
	logic [PW:0] fill;
	logic full;
	logic do_wr;
	logic do_rd;

	assign fill = wr_ptr - rd_ptr;
	assign o_empty = (fill == '0);
	assign full = (fill == (PW+1)'(DEPTH));

	assign do_rd = i_rd && !o_empty;
	// A full FIFO still takes a write if a read frees a slot
	assign do_wr = i_wr && (!full || do_rd);

	////////////////////////////////////////////////////////////
	// Pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (do_wr)
			mem[wr_ptr[PW-1:0]] <= i_data;
	end

	assign o_data = mem[rd_ptr[PW-1:0]];

endmodule

// File: verilog/insn_unpack.sv
// Instructions leave in address order, lowest lane of a bus word first
// After a bus error o_pc freezes and o_illegal holds until a flush

`timescale 1ns/1ns
`include "fetch_cfg.svh"

module insn_unpack (
	input  logic                     S_AXI_ACLK,
	input  logic                     fifo_reset,
	input  fetch_pkg::flush_cmd_t    i_flush,
	input  logic [`FETCH_AW-1:0]     i_pc,
	input  fetch_pkg::fifo_entry_t   i_entry,
	input  logic                     i_empty,
	input  logic                     i_ready,
	output logic                     o_rd,
	output logic                     o_consumed,
	output logic [`FETCH_INSN_W-1:0] o_insn,
	output logic [`FETCH_AW-1:0]     o_pc,
	output logic                     o_valid,
	output logic                     o_illegal
);

	localparam int LSB = $clog2(`FETCH_BUS_DW / 8);
	localparam int BPI = `FETCH_INSN_W / 8;
	localparam int IL = $clog2(BPI);
	localparam int NI = `FETCH_INSNS_PER_WORD;
	localparam int IW = $clog2(NI);
	localparam logic [IW-1:0] LAST_IDX = IW'(NI - 1);

	fetch_pkg::bus_beat_u swapped;
	fetch_pkg::bus_beat_u cur_word;
	logic [IW-1:0] idx;
	logic [IW-1:0] start_idx;
	logic last;
	logic take;

	////////////////////////////////////////////////////////////
	// Byte swap, little-endian bus to big-endian CPU
	////////////////////////////////////////////////////////////

	// Reverse the bytes inside each instruction lane
	always_comb
	begin
		for (int l = 0; l < NI; l++)
		begin
			for (int b = 0; b < BPI; b++)
				swapped.bytes[l*BPI + BPI-1-b] = i_entry.word.bytes[l*BPI + b];
		end
	end

	////////////////////////////////////////////////////////////
	// Output register and splitter
	////////////////////////////////////////////////////////////

	assign take = o_valid && i_ready;
	assign last = (idx == LAST_IDX);

	// Only the first word after a new PC can start mid-word
	assign start_idx = o_valid ? '0 : o_pc[LSB-1:IL];

	assign o_rd = !i_empty && (!o_valid || (i_ready && last));
	assign o_consumed = take && last;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_flush.flush)
		begin
			o_valid <= 1'b0;
			idx <= '0;
		end
		else if (o_rd)
		begin
			o_valid <= 1'b1;
			idx <= start_idx;
		end
		else if (take)
		begin
			if (last)
				o_valid <= 1'b0;
			else
				idx <= idx + 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_rd)
			cur_word <= swapped;
	end

	assign o_insn = cur_word.insns[idx];

	////////////////////////////////////////////////////////////
	// PC and bus error
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			o_pc <= '0;
		else if (i_flush.new_pc)
			o_pc <= i_pc;
		else if (take && !o_illegal)
		begin
			o_pc[`FETCH_AW-1:IL] <= o_pc[`FETCH_AW-1:IL] + 1'b1;
			o_pc[IL-1:0] <= '0;
		end
	end

	// Latch the error with the word, hold until a flush
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_flush.flush)
			o_illegal <= 1'b0;
		else if (!o_illegal && o_rd)
			o_illegal <= i_entry.err;
	end

endmodule

// File: verilog/axil_fetch_top.sv
// AXI-lite instruction fetch, read address and read data channels only
// RREADY is taken as high, RRESP[1] marks a failed read

`timescale 1ns/1ns
`include "fetch_cfg.svh"

module axil_fetch_top (
	input  logic                     S_AXI_ACLK,
	input  logic                     fifo_reset,
	// CPU side
	input  logic                     i_cpu_reset,
	input  logic                     i_new_pc,
	input  logic                     i_clear_cache,
	input  logic                     i_ready,
	input  logic [`FETCH_AW-1:0]     i_pc,
	// AXI-lite read channels
	input  logic                     i_arready,
	input  logic                     i_rvalid,
	input  logic [`FETCH_BUS_DW-1:0] i_rdata,
	input  logic [1:0]               i_rresp,
	output logic                     o_arvalid,
	output logic [`FETCH_AW-1:0]     o_araddr,
	// Instruction out
	output logic [`FETCH_INSN_W-1:0] o_insn,
	output logic [`FETCH_AW-1:0]     o_pc,
	output logic                     o_valid,
	output logic                     o_illegal
);

	fetch_pkg::flush_cmd_t flush;
	fetch_pkg::fifo_entry_t fifo_in;
	fetch_pkg::fifo_entry_t fifo_out;
	logic keep;
	logic fifo_rd;
	logic fifo_empty;
	logic consumed;

	// Flush strobes go straight through, no register
	always_comb
	begin
		flush.halt = i_cpu_reset || i_clear_cache;
		flush.new_pc = i_new_pc;
		flush.flush = i_cpu_reset || i_clear_cache || i_new_pc;
	end

	always_comb
	begin
		fifo_in.err = i_rresp[1];
		fifo_in.word = i_rdata;
	end

	fetch_request u_fetch_request (
		.S_AXI_ACLK (S_AXI_ACLK),
		.fifo_reset (fifo_reset),
		.i_flush    (flush),
		.i_pc       (i_pc),
		.i_arready  (i_arready),
		.i_rvalid   (i_rvalid),
		.i_consumed (consumed),
		.o_arvalid  (o_arvalid),
		.o_araddr   (o_araddr),
		.o_keep     (keep)
	);

	sync_fifo #(
		.DEPTH (`FETCH_LIMIT)
	) u_sync_fifo (
		.S_AXI_ACLK (S_AXI_ACLK),
		.fifo_reset (fifo_reset),
		.i_clear    (flush.flush),
		.i_wr       (keep),
		.i_data     (fifo_in),
		.i_rd       (fifo_rd),
		.o_data     (fifo_out),
		.o_empty    (fifo_empty)
	);

	insn_unpack u_insn_unpack (
		.S_AXI_ACLK (S_AXI_ACLK),
		.fifo_reset (fifo_reset),
		.i_flush    (flush),
		.i_pc       (i_pc),
		.i_entry    (fifo_out),
		.i_empty    (fifo_empty),
		.i_ready    (i_ready),
		.o_rd       (fifo_rd),
		.o_consumed (consumed),
		.o_insn     (o_insn),
		.o_pc       (o_pc),
		.o_valid    (o_valid),
		.o_illegal  (o_illegal)
	);

endmodule

// File: verif/axil_rom_model.sv
// In-order AXI-lite read slave, RREADY is taken as always high
// Each 32-bit lane holds its byte address XOR KEY, little-endian on the bus
// Reads at or above ERR_BASE answer with SLVERR

`timescale 1ns/1ns

module axil_rom_model #(
	parameter int          SEED     = 17226,
	parameter logic [31:0] KEY      = 32'h5a3c_96e1,
	parameter logic [31:0] ERR_BASE = 32'h0000_1000
) (
	input  logic        S_AXI_ACLK,
	input  logic        fifo_reset,
	input  logic        i_stall,
	input  logic        i_arvalid,
	input  logic [31:0] i_araddr,
	output logic        o_arready,
	output logic        o_rvalid,
	output logic [63:0] o_rdata,
	output logic [1:0]  o_rresp
);

	integer seed;
	int delay;
	logic [31:0] pending [$];

	// Byte-reversed so the fetch unit's swap restores the value
	function automatic logic [31:0] lane_bytes(input logic [31:0] addr);
		logic [31:0] v;
		v = addr ^ KEY;
		return {v[7:0], v[15:8], v[23:16], v[31:24]};
	endfunction

	initial
	begin
		seed = SEED;
		delay = 0;
		o_arready = 1'b0;
		o_rvalid = 1'b0;
		o_rdata = '0;
		o_rresp = 2'b00;
	end

	// Inputs sampled on the edge, outputs driven 1 ns later
	always @(posedge S_AXI_ACLK)
	begin
		logic [31:0] addr;
		logic stall;
		if (!fifo_reset && i_arvalid && o_arready)
			pending.push_back({i_araddr[31:3], 3'b000});
		stall = i_stall;
		#1;
		o_rvalid = 1'b0;
		if (fifo_reset)
		begin
			pending.delete();
			o_arready = 1'b0;
		end
		else
		begin
			o_arready = !stall && (($unsigned($random(seed)) % 4) != 0);
			if (pending.size() != 0 && delay != 0)
				delay--;
			else if (pending.size() != 0)
			begin
				addr = pending.pop_front();
				o_rvalid = 1'b1;
				o_rdata = {lane_bytes(addr + 32'd4), lane_bytes(addr)};
				o_rresp = (addr >= ERR_BASE) ? 2'b10 : 2'b00;
				// Gap before the next response, 0 to 3 cycles
				delay = $unsigned($random(seed)) % 4;
			end
		end
	end

endmodule

// File: verif/tb_axil_fetch.sv
// Checks every accepted instruction against the ROM contents rule
// Flush cycles hold the CPU ready low, so no instruction is taken with them

`timescale 1ns/1ns
`include "fetch_cfg.svh"

module tb_axil_fetch;

	localparam logic [31:0] ROM_KEY = 32'h5a3c_96e1;
	localparam logic [31:0] ERR_BASE = 32'h0000_1000;
	localparam int TIMEOUT = 2000;
	localparam int EV_ACCEPTED = 0;
	localparam int EV_AR_STALLED = 1;
	localparam int EV_AR_QUIET = 2;
	localparam int EV_ILLEGAL = 3;
	localparam int EV_FULL = 4;

	logic S_AXI_ACLK = 1'b0;
	logic fifo_reset;
	logic cpu_reset;
	logic new_pc;
	logic clear_cache;
	logic cpu_ready;
	logic slow_ready;
	logic ar_stall;
	logic [`FETCH_AW-1:0] pc;
	logic arready;
	logic rvalid;
	logic [`FETCH_BUS_DW-1:0] rdata;
	logic [1:0] rresp;
	logic arvalid;
	logic [`FETCH_AW-1:0] araddr;
	logic [`FETCH_INSN_W-1:0] insn;
	logic [`FETCH_AW-1:0] insn_pc;
	logic valid;
	logic illegal;

	// Monitor state
	integer seed;
	int accepted;
	int words_open;
	logic tracking;
	logic seen_illegal;
	logic halted;
	logic ar_quiet;
	logic ar_stall_seen;
	logic stale_ar;
	logic [`FETCH_AW-1:0] exp_pc;

	// Snapshot from the previous cycle
	logic prev_flush;
	logic prev_new_pc;
	logic prev_ar_free;
	logic prev_ar_stall;
	logic prev_hold;
	logic prev_illegal;
	logic [`FETCH_AW-1:0] prev_pc_in;
	logic [`FETCH_AW-1:0] prev_araddr;
	logic [`FETCH_INSN_W-1:0] prev_insn;
	logic [`FETCH_AW-1:0] prev_insn_pc;

	always #50 S_AXI_ACLK = ~S_AXI_ACLK;

	axil_fetch_top u_axil_fetch_top (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.fifo_reset    (fifo_reset),
		.i_cpu_reset   (cpu_reset),
		.i_new_pc      (new_pc),
		.i_clear_cache (clear_cache),
		.i_ready       (cpu_ready),
		.i_pc          (pc),
		.i_arready     (arready),
		.i_rvalid      (rvalid),
		.i_rdata       (rdata),
		.i_rresp       (rresp),
		.o_arvalid     (arvalid),
		.o_araddr      (araddr),
		.o_insn        (insn),
		.o_pc          (insn_pc),
		.o_valid       (valid),
		.o_illegal     (illegal)
	);

	axil_rom_model #(
		.SEED     (17226),
		.KEY      (ROM_KEY),
		.ERR_BASE (ERR_BASE)
	) u_axil_rom_model (
		.S_AXI_ACLK (S_AXI_ACLK),
		.fifo_reset (fifo_reset),
		.i_stall    (ar_stall),
		.i_arvalid  (arvalid),
		.i_araddr   (araddr),
		.o_arready  (arready),
		.o_rvalid   (rvalid),
		.o_rdata    (rdata),
		.o_rresp    (rresp)
	);

	task automatic end_with_failure();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic value_error(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		end_with_failure();
	endtask

	task automatic timed_out(input string what);
		$display("Timeout while waiting for %s", what);
		end_with_failure();
	endtask

	////////////////////////////////////////////////////////////
	// Checks, sampled mid-cycle where everything is settled
	////////////////////////////////////////////////////////////

	always @(negedge S_AXI_ACLK)
	begin
		logic flush_now;
		flush_now = new_pc || clear_cache || cpu_reset;
		if (!fifo_reset)
		begin
			assert (!prev_flush || (!valid && !illegal))
				else value_error("instruction output not cleared after a flush");
			assert (!(prev_new_pc && prev_ar_free) || araddr == prev_pc_in)
				else value_error($sformatf("araddr %h after new PC %h", araddr, prev_pc_in));
			assert (!prev_ar_stall || (arvalid && araddr == prev_araddr))
				else value_error("read request changed while stalled");
			assert (!prev_hold || (valid && insn == prev_insn && insn_pc == prev_insn_pc &&
				illegal == prev_illegal))
				else value_error("instruction output changed while the CPU was not ready");
			assert (!halted || !valid)
				else value_error("instruction valid while halted");
			assert (!ar_quiet || !arvalid)
				else value_error("read issued while halted");
			assert (!seen_illegal || illegal)
				else value_error("illegal flag dropped before a new PC");

			if (tracking && valid && cpu_ready)
			begin
				assert (insn_pc == exp_pc)
					else value_error($sformatf("pc %h, expected %h", insn_pc, exp_pc));
				if (illegal)
				begin
					assert (insn_pc >= ERR_BASE)
						else value_error($sformatf("illegal at pc %h", insn_pc));
					seen_illegal = 1'b1;
				end
				else
				begin
					assert (insn_pc < ERR_BASE && insn == (insn_pc ^ ROM_KEY))
						else value_error($sformatf("insn %h at pc %h", insn, insn_pc));
					exp_pc = exp_pc + 32'd4;
					// Upper lane taken, whole word consumed
					if (insn_pc[2])
						words_open--;
				end
				accepted++;
			end

			// A request stalled across a flush belongs to the old stream
			if (arvalid && arready)
			begin
				if (stale_ar)
					stale_ar = 1'b0;
				else
					words_open++;
			end
			assert (seen_illegal || words_open <= `FETCH_LIMIT)
				else value_error($sformatf("%0d words requested and not consumed", words_open));

			ar_stall_seen = arvalid && !arready;
			if (halted && !arvalid)
				ar_quiet = 1'b1;
			if (flush_now)
			begin
				words_open = 0;
				stale_ar = arvalid && !arready;
				seen_illegal = 1'b0;
				ar_quiet = 1'b0;
				halted = !new_pc;
				if (new_pc)
				begin
					tracking = 1'b1;
					exp_pc = pc;
				end
			end
		end
		prev_flush = flush_now;
		prev_new_pc = new_pc;
		prev_pc_in = pc;
		prev_ar_free = !arvalid || arready;
		prev_ar_stall = arvalid && !arready;
		prev_araddr = araddr;
		prev_hold = valid && !cpu_ready && !flush_now;
		prev_insn = insn;
		prev_insn_pc = insn_pc;
		prev_illegal = illegal;
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// CPU ready is low about one cycle in four, or mostly low when slow
	task automatic next_cycle();
		@(posedge S_AXI_ACLK);
		#1;
		if (slow_ready)
			cpu_ready = ($unsigned($random(seed)) % 16) == 0;
		else
			cpu_ready = ($unsigned($random(seed)) % 4) != 0;
	endtask

	function automatic logic event_reached(input int which, input int target);
		case (which)
		EV_ACCEPTED: return accepted >= target;
		EV_AR_STALLED: return ar_stall_seen;
		EV_AR_QUIET: return ar_quiet;
		EV_FULL: return words_open >= `FETCH_LIMIT;
		default: return seen_illegal;
		endcase
	endfunction

	task automatic wait_for_event(input string what, input int which, input int target);
		int n;
		n = 0;
		next_cycle();
		while (!event_reached(which, target))
		begin
			if (n == TIMEOUT)
				timed_out(what);
			n++;
			next_cycle();
		end
	endtask

	task automatic give_new_pc(input logic [`FETCH_AW-1:0] addr);
		cpu_ready = 1'b0;
		pc = addr;
		new_pc = 1'b1;
		next_cycle();
		new_pc = 1'b0;
	endtask

	task automatic pulse_halt(input logic by_cpu_reset);
		cpu_ready = 1'b0;
		cpu_reset = by_cpu_reset;
		clear_cache = !by_cpu_reset;
		next_cycle();
		cpu_reset = 1'b0;
		clear_cache = 1'b0;
	endtask

	initial
	begin
		fifo_reset = 1'b1;
		cpu_reset = 1'b0;
		new_pc = 1'b0;
		clear_cache = 1'b0;
		cpu_ready = 1'b0;
		slow_ready = 1'b0;
		ar_stall = 1'b0;
		pc = '0;
		seed = 17226;
		accepted = 0;
		words_open = 0;
		tracking = 1'b0;
		seen_illegal = 1'b0;
		halted = 1'b0;
		ar_quiet = 1'b0;
		ar_stall_seen = 1'b0;
		stale_ar = 1'b0;
		exp_pc = '0;
		repeat (8) @(posedge S_AXI_ACLK);
		#1;
		fifo_reset = 1'b0;
		next_cycle();

		// Aligned start, then an unaligned redirect mid-stream
		give_new_pc(32'h0000_0100);
		wait_for_event("sequential fetch", EV_ACCEPTED, accepted + 40);

		// Slow CPU fills the unit up to the fetch limit
		slow_ready = 1'b1;
		wait_for_event("the fetch limit", EV_FULL, 0);
		repeat (40) next_cycle();
		slow_ready = 1'b0;
		wait_for_event("fetch after back-pressure", EV_ACCEPTED, accepted + 20);

		give_new_pc(32'h0000_0204);
		wait_for_event("unaligned fetch", EV_ACCEPTED, accepted + 20);

		// Redirect while a read request is stalled
		ar_stall = 1'b1;
		wait_for_event("a stalled read request", EV_AR_STALLED, 0);
		give_new_pc(32'h0000_0404);
		repeat (3) next_cycle();
		ar_stall = 1'b0;
		wait_for_event("fetch after a stalled redirect", EV_ACCEPTED, accepted + 20);

		// Cache clear, then CPU reset, each until the next new PC
		pulse_halt(1'b0);
		wait_for_event("reads to stop after a cache clear", EV_AR_QUIET, 0);
		repeat (20) next_cycle();
		give_new_pc(32'h0000_0500);
		wait_for_event("fetch after a cache clear", EV_ACCEPTED, accepted + 12);
		pulse_halt(1'b1);
		wait_for_event("reads to stop after a CPU reset", EV_AR_QUIET, 0);
		repeat (10) next_cycle();

		// Run into the error region, PC must freeze there
		give_new_pc(ERR_BASE - 32'd16);
		wait_for_event("the bus error", EV_ILLEGAL, 0);
		wait_for_event("instructions after the bus error", EV_ACCEPTED, accepted + 8);
		give_new_pc(32'h0000_0300);
		wait_for_event("fetch after the bus error", EV_ACCEPTED, accepted + 16);

		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: compile.f
+incdir+common
common/fetch_pkg.sv
verilog/fetch_request.sv
verilog/sync_fifo.sv
verilog/insn_unpack.sv
verilog/axil_fetch_top.sv
verif/axil_rom_model.sv
verif/tb_axil_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the fetch unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_axil_fetch -f compile.f --Mdir obj_dir -o Vtb_axil_fetch

output=$(./obj_dir/Vtb_axil_fetch 2>&1) || true
echo "$output"

if grep -qx "Finished with no errors" <<< "$output"; then
	exit 0
fi
exit 1
